//--- run_sim.sh
#!/bin/sh
# Build and run the SAR DAC testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal -f sim.f \
    --top-module tb_sar_dac -Mdir obj_dir
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

output=$(./obj_dir/Vtb_sar_dac)
status=$?
echo "$output"
if [ $status -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi

if echo "$output" | grep -qF '*** PASSED ***'; then
    exit 0
fi
echo "Pass message not found in simulation output"
exit 1

//--- sar_cal_trim.sv
//======================================================================
// Trim stage of the SAR DAC pipeline
// Holds the calibration word and applies digital offset and gain
// trim, saturated to the full scale of the item's resolution
//======================================================================

`timescale 1ns/1ns

`include "sar_dac_params.svh"

module sar_cal_trim (
    input  logic                     clk_i,
    input  logic                     reset_n_i,
    // From the capture stage
    input  logic                     cap_valid_i,
    output logic                     cap_ready_o,
    input  logic [`SAR_MAX_BITS-1:0] cap_code_i,
    input  logic [4:0]               cap_bits_i,
    input  logic [`SAR_MAX_BITS-1:0] cap_high_i,
    input  logic [`SAR_MAX_BITS-1:0] cap_low_i,
    input  logic [`SAR_MAX_BITS-1:0] cap_mid_i,
    // Calibration load and enable
    input  logic                     cal_valid_i,
    input  logic [`SAR_CAL_BITS-1:0] cal_code_i,
    input  logic                     cal_enable_i,
    // Toward the settle stage
    output logic                     trim_valid_o,
    input  logic                     trim_ready_i,
    output logic [`SAR_MAX_BITS-1:0] trim_level_o,
    output logic [4:0]               trim_bits_o,
    output logic [`SAR_MAX_BITS-1:0] trim_high_o,
    output logic [`SAR_MAX_BITS-1:0] trim_low_o,
    output logic [`SAR_MAX_BITS-1:0] trim_mid_o
);

    import sar_dac_pkg::*;

    localparam int NIB_W = `SAR_CAL_BITS / 2;
    // Accumulator wide enough for code times the largest gain step
    localparam int ACC_W = `SAR_MAX_BITS + 6;
    localparam logic [NIB_W-1:0]  TRIM_MID   = `SAR_TRIM_MID;
    localparam logic signed [4:0] TRIM_MID_S = `SAR_TRIM_MID;

    logic [`SAR_CAL_BITS-1:0] cal_q;
    logic signed [4:0]        gain_step;
    logic signed [4:0]        offset_step;
    logic signed [ACC_W-1:0]  gain_prod;
    logic signed [ACC_W-1:0]  gain_corr;
    logic signed [ACC_W-1:0]  trim_sum;
    logic [`SAR_MAX_BITS-1:0] level_d;
    logic                     take;

    // Calibration word, reset to zero trim on both nibbles
    always_ff @(posedge clk_i or negedge reset_n_i) begin
        if (!reset_n_i) begin
            cal_q <= {TRIM_MID, TRIM_MID};
        end else if (cal_valid_i) begin
            cal_q <= cal_code_i;
        end
    end

    //==================================================================
    // Offset and gain arithmetic
    //==================================================================

    // Nibbles recentred around the midpoint, -8 .. +7
    assign gain_step   = $signed({1'b0, cal_q[`SAR_CAL_BITS-1:NIB_W]}) - TRIM_MID_S;
    assign offset_step = $signed({1'b0, cal_q[NIB_W-1:0]}) - TRIM_MID_S;

    assign gain_prod = $signed({1'b0, cap_code_i}) * gain_step;
    // Arithmetic shift, rounds toward minus infinity
    assign gain_corr = gain_prod >>> `SAR_GAIN_SHIFT;
    assign trim_sum  = $signed({6'b000000, cap_code_i}) + gain_corr + offset_step;

    // Bypass gives the masked code back untouched
    assign level_d = cal_enable_i ? sar_sat(trim_sum[`SAR_MAX_BITS+1:0], cap_bits_i)
                                  : cap_code_i;

    //==================================================================
    // Handshake and register
    //==================================================================

    assign cap_ready_o = !trim_valid_o || trim_ready_i;
    assign take        = cap_valid_i && cap_ready_o;

    always_ff @(posedge clk_i or negedge reset_n_i) begin
        if (!reset_n_i) begin
            trim_valid_o <= 1'b0;
        end else if (cap_ready_o) begin
            trim_valid_o <= cap_valid_i;
        end
    end

    // Switch vectors ride along unchanged
    always_ff @(posedge clk_i) begin
        if (take) begin
            trim_level_o <= level_d;
            trim_bits_o  <= cap_bits_i;
            trim_high_o  <= cap_high_i;
            trim_low_o   <= cap_low_i;
            trim_mid_o   <= cap_mid_i;
        end
    end

    // Trimmed level stays inside the item's full scale
    assert property (@(posedge clk_i) disable iff (!reset_n_i)
        trim_valid_o |-> (trim_level_o <= sar_max_code(trim_bits_o)))
    else $error("trimmed level above full scale");

endmodule

//--- sar_code_capture.sv
//======================================================================
// Capture stage of the SAR DAC pipeline
// Masks the request code to its resolution and decodes the
// per-capacitor high, low and mid switch vectors into a register
//======================================================================

`timescale 1ns/1ns

`include "sar_dac_params.svh"

module sar_code_capture (
    input  logic                     clk_i,
    input  logic                     reset_n_i,
    // Request side
    input  logic                     in_valid_i,
    output logic                     in_ready_o,
    input  logic [`SAR_MAX_BITS-1:0] in_code_i,
    input  logic [1:0]               in_res_i,
    input  logic                     in_mid_i,
    // Toward the trim stage
    output logic                     cap_valid_o,
    input  logic                     cap_ready_i,
    output logic [`SAR_MAX_BITS-1:0] cap_code_o,
    output logic [4:0]               cap_bits_o,
    output logic [`SAR_MAX_BITS-1:0] cap_high_o,
    output logic [`SAR_MAX_BITS-1:0] cap_low_o,
    output logic [`SAR_MAX_BITS-1:0] cap_mid_o
);

    import sar_dac_pkg::*;

    logic [4:0]               res_bits;
    logic [`SAR_MAX_BITS-1:0] used_mask;
    logic [`SAR_MAX_BITS-1:0] mid_fill;
    logic [`SAR_MAX_BITS-1:0] code_d;
    logic                     take;

    //==================================================================
    // Decode
    //==================================================================

    assign res_bits  = sar_res_bits(in_res_i);
    // Ones on every capacitor the resolution uses
    assign used_mask = sar_max_code(res_bits);
    assign mid_fill  = {`SAR_MAX_BITS{in_mid_i}};

    // Midscale code is the top used bit alone
    assign code_d = in_mid_i ? ({{(`SAR_MAX_BITS-1){1'b0}}, 1'b1} << (res_bits - 5'd1))
                             : (in_code_i & used_mask);

    //==================================================================
    // Handshake and register
    //==================================================================

    // Room when empty or when the held item leaves this cycle
    assign in_ready_o = !cap_valid_o || cap_ready_i;
    assign take       = in_valid_i && in_ready_o;

    always_ff @(posedge clk_i or negedge reset_n_i) begin
        if (!reset_n_i) begin
            cap_valid_o <= 1'b0;
        end else if (in_ready_o) begin
            cap_valid_o <= in_valid_i;
        end
    end

    // Payload loaded only on a transfer
    always_ff @(posedge clk_i) begin
        if (take) begin
            cap_code_o <= code_d;
            cap_bits_o <= res_bits;
            // Used bits follow the code unless midscale is forced
            cap_high_o <= in_code_i & used_mask & ~mid_fill;
            cap_low_o  <= ~in_code_i & used_mask & ~mid_fill;
            // Unused bits always park at mid
            cap_mid_o  <= ~used_mask | mid_fill;
        end
    end

endmodule

//--- sar_dac_params.svh
//======================================================================
// Width and timing constants for the SAR DAC control pipeline
// Included by the package and by every stage and the top level
//======================================================================

`ifndef SAR_DAC_PARAMS_SVH
`define SAR_DAC_PARAMS_SVH

// Widest code, also one switch vector per capacitor
`define SAR_MAX_BITS 16

// Calibration word, offset nibble low and gain nibble high
`define SAR_CAL_BITS 8

// Nibble value meaning no trim
`define SAR_TRIM_MID 8

// One gain step is code/1024
`define SAR_GAIN_SHIFT 10

// Settling wait in clocks after the switches are driven
`define SAR_SETTLE_CYCLES 8

`endif

//--- sar_dac_pkg.sv
//======================================================================
// Shared helpers for the SAR DAC pipeline stages
// Resolution decode, full-scale code and saturation to full scale
//======================================================================

`include "sar_dac_params.svh"

package sar_dac_pkg;

    // Resolution select to effective bit count
    // 0 is 12 bits, 1 is 14 bits, anything else is full width
    function automatic logic [4:0] sar_res_bits(input logic [1:0] sel);
        case (sel)
            2'd0:    return 5'd12;
            2'd1:    return 5'd14;
            default: return 5'd16;
        endcase
    endfunction

    // All ones below the resolution, 2^bits - 1
    function automatic logic [`SAR_MAX_BITS-1:0] sar_max_code(input logic [4:0] bits);
        logic [`SAR_MAX_BITS:0] full;
        // One extra bit so that 16 bits does not wrap before the subtract
        full = ({{`SAR_MAX_BITS{1'b0}}, 1'b1} << bits) - 1'b1;
        return full[`SAR_MAX_BITS-1:0];
    endfunction

    // Clamp a signed trim result into 0 .. max code
    function automatic logic [`SAR_MAX_BITS-1:0] sar_sat(
        input logic signed [`SAR_MAX_BITS+1:0] value,
        input logic [4:0]                      bits
    );
        logic [`SAR_MAX_BITS-1:0] max_c;
        max_c = sar_max_code(bits);
        if (value < 0)
            return '0;
        else if (value > $signed({2'b00, max_c}))
            return max_c;
        else
            return value[`SAR_MAX_BITS-1:0];
    endfunction

endpackage

//--- sar_dac_top.sv
//======================================================================
// SAR DAC control pipeline top level
// Chains capture, trim and settle stages on valid/ready hops
//======================================================================

`timescale 1ns/1ns

`include "sar_dac_params.svh"

module sar_dac_top (
    input  logic                     clk_i,
    input  logic                     reset_n_i,
    // Conversion requests
    input  logic                     req_valid_i,
    output logic                     req_ready_o,
    input  logic [`SAR_MAX_BITS-1:0] req_code_i,
    input  logic [1:0]               req_res_i,
    input  logic                     req_mid_i,
    // Calibration
    input  logic                     cal_valid_i,
    input  logic [`SAR_CAL_BITS-1:0] cal_code_i,
    input  logic                     cal_enable_i,
    // Settled result and array switches
    output logic                     out_valid_o,
    input  logic                     out_ready_i,
    output logic [`SAR_MAX_BITS-1:0] out_level_o,
    output logic [`SAR_MAX_BITS-1:0] sw_high_o,
    output logic [`SAR_MAX_BITS-1:0] sw_low_o,
    output logic [`SAR_MAX_BITS-1:0] sw_mid_o,
    output logic                     busy_o
);

    // Capture to trim
    logic                     cap_valid;
    logic                     cap_ready;
    logic [`SAR_MAX_BITS-1:0] cap_code;
    logic [4:0]               cap_bits;
    logic [`SAR_MAX_BITS-1:0] cap_high;
    logic [`SAR_MAX_BITS-1:0] cap_low;
    logic [`SAR_MAX_BITS-1:0] cap_mid;

    // Trim to settle
    logic                     trim_valid;
    logic                     trim_ready;
    logic [`SAR_MAX_BITS-1:0] trim_level;
    logic [4:0]               trim_bits;
    logic [`SAR_MAX_BITS-1:0] trim_high;
    logic [`SAR_MAX_BITS-1:0] trim_low;
    logic [`SAR_MAX_BITS-1:0] trim_mid;

    sar_code_capture u_capture (
        .clk_i       (clk_i),
        .reset_n_i   (reset_n_i),
        .in_valid_i  (req_valid_i),
        .in_ready_o  (req_ready_o),
        .in_code_i   (req_code_i),
        .in_res_i    (req_res_i),
        .in_mid_i    (req_mid_i),
        .cap_valid_o (cap_valid),
        .cap_ready_i (cap_ready),
        .cap_code_o  (cap_code),
        .cap_bits_o  (cap_bits),
        .cap_high_o  (cap_high),
        .cap_low_o   (cap_low),
        .cap_mid_o   (cap_mid)
    );

    sar_cal_trim u_trim (
        .clk_i        (clk_i),
        .reset_n_i    (reset_n_i),
        .cap_valid_i  (cap_valid),
        .cap_ready_o  (cap_ready),
        .cap_code_i   (cap_code),
        .cap_bits_i   (cap_bits),
        .cap_high_i   (cap_high),
        .cap_low_i    (cap_low),
        .cap_mid_i    (cap_mid),
        .cal_valid_i  (cal_valid_i),
        .cal_code_i   (cal_code_i),
        .cal_enable_i (cal_enable_i),
        .trim_valid_o (trim_valid),
        .trim_ready_i (trim_ready),
        .trim_level_o (trim_level),
        .trim_bits_o  (trim_bits),
        .trim_high_o  (trim_high),
        .trim_low_o   (trim_low),
        .trim_mid_o   (trim_mid)
    );

    sar_settle_timer u_settle (
        .clk_i        (clk_i),
        .reset_n_i    (reset_n_i),
        .trim_valid_i (trim_valid),
        .trim_ready_o (trim_ready),
        .trim_level_i (trim_level),
        .trim_bits_i  (trim_bits),
        .trim_high_i  (trim_high),
        .trim_low_i   (trim_low),
        .trim_mid_i   (trim_mid),
        .out_valid_o  (out_valid_o),
        .out_ready_i  (out_ready_i),
        .out_level_o  (out_level_o),
        .sw_high_o    (sw_high_o),
        .sw_low_o     (sw_low_o),
        .sw_mid_o     (sw_mid_o),
        .busy_o       (busy_o)
    );

endmodule

//--- sar_settle_timer.sv
//======================================================================
// Settle stage of the SAR DAC pipeline
// Drives the switch vectors to the array on accept, waits the fixed
// settling interval and then offers the level on the output handshake
//======================================================================

`timescale 1ns/1ns

`include "sar_dac_params.svh"

module sar_settle_timer (
    input  logic                     clk_i,
    input  logic                     reset_n_i,
    // From the trim stage
    input  logic                     trim_valid_i,
    output logic                     trim_ready_o,
    input  logic [`SAR_MAX_BITS-1:0] trim_level_i,
    input  logic [4:0]               trim_bits_i,
    input  logic [`SAR_MAX_BITS-1:0] trim_high_i,
    input  logic [`SAR_MAX_BITS-1:0] trim_low_i,
    input  logic [`SAR_MAX_BITS-1:0] trim_mid_i,
    // Output handshake and array switches
    output logic                     out_valid_o,
    input  logic                     out_ready_i,
    output logic [`SAR_MAX_BITS-1:0] out_level_o,
    output logic [`SAR_MAX_BITS-1:0] sw_high_o,
    output logic [`SAR_MAX_BITS-1:0] sw_low_o,
    output logic [`SAR_MAX_BITS-1:0] sw_mid_o,
    output logic                     busy_o
);

    import sar_dac_pkg::*;

    localparam int CNT_W = $clog2(`SAR_SETTLE_CYCLES + 1);
    localparam logic [CNT_W-1:0] CNT_LOAD = CNT_W'(`SAR_SETTLE_CYCLES - 1);

    logic [CNT_W-1:0] cnt_q;
    logic [4:0]       bits_q;
    logic             deliver;
    logic             take;

    assign deliver = out_valid_o && out_ready_i;
    // One item at a time, refilled on the delivery cycle
    assign trim_ready_o = !busy_o || deliver;
    assign take         = trim_valid_i && trim_ready_o;

    //==================================================================
    // Settle FSM and switch drive
    //==================================================================

    always_ff @(posedge clk_i or negedge reset_n_i) begin
        if (!reset_n_i) begin
            busy_o      <= 1'b0;
            out_valid_o <= 1'b0;
            cnt_q       <= '0;
            sw_high_o   <= '0;
            sw_low_o    <= '0;
            // Array parks at midscale out of reset
            sw_mid_o    <= '1;
        end else if (take) begin
            busy_o      <= 1'b1;
            out_valid_o <= 1'b0;
            cnt_q       <= CNT_LOAD;
            sw_high_o   <= trim_high_i;
            sw_low_o    <= trim_low_i;
            sw_mid_o    <= trim_mid_i;
        end else if (deliver) begin
            busy_o      <= 1'b0;
            out_valid_o <= 1'b0;
        end else if (busy_o && !out_valid_o) begin
            // Level shows exactly SAR_SETTLE_CYCLES clocks after accept
            if (cnt_q == '0)
                out_valid_o <= 1'b1;
            else
                cnt_q <= cnt_q - 1'b1;
        end
    end

    // Level and resolution held with the item
    always_ff @(posedge clk_i) begin
        if (take) begin
            out_level_o <= trim_level_i;
            bits_q      <= trim_bits_i;
        end
    end

    // Offered level holds until the consumer takes it
    assert property (@(posedge clk_i) disable iff (!reset_n_i)
        (out_valid_o && !out_ready_i) |=> (out_valid_o && $stable(out_level_o)))
    else $error("output level dropped or changed before transfer");

    // Capacitors above the resolution reach the array at mid
    assert property (@(posedge clk_i) disable iff (!reset_n_i)
        out_valid_o |-> ((sw_mid_o | sar_max_code(bits_q)) == '1))
    else $error("unused capacitor not parked at mid");

endmodule

//--- sim.f
+incdir+.
sar_dac_pkg.sv
sar_code_capture.sv
sar_cal_trim.sv
sar_settle_timer.sv
sar_dac_top.sv
tb_sar_dac.sv

//--- tb_sar_dac.sv
//======================================================================
// Self-checking testbench for the SAR DAC control pipeline
// Applies a table of requests through the input handshake, loads the
// calibration word between groups and checks every settled result
// against the table while the output side stalls at random
//======================================================================

`timescale 1ns/1ns

`include "sar_dac_params.svh"

module tb_sar_dac;

    localparam int NUM_ROWS     = 21;
    localparam int RESET_CYCLES = 3;
    // Worst case per row is the settle wait plus handshake slack
    localparam int WATCHDOG_CYCLES = NUM_ROWS * (`SAR_SETTLE_CYCLES + 20) + RESET_CYCLES + 10;

    logic                     clk_i;
    logic                     reset_n_i;
    logic                     req_valid_i;
    logic                     req_ready_o;
    logic [`SAR_MAX_BITS-1:0] req_code_i;
    logic [1:0]               req_res_i;
    logic                     req_mid_i;
    logic                     cal_valid_i;
    logic [`SAR_CAL_BITS-1:0] cal_code_i;
    logic                     cal_enable_i;
    logic                     out_valid_o;
    logic                     out_ready_i;
    logic [`SAR_MAX_BITS-1:0] out_level_o;
    logic [`SAR_MAX_BITS-1:0] sw_high_o;
    logic [`SAR_MAX_BITS-1:0] sw_low_o;
    logic [`SAR_MAX_BITS-1:0] sw_mid_o;
    logic                     busy_o;

    // Stimulus and expected columns, one entry per row
    logic [`SAR_MAX_BITS-1:0] row_code  [NUM_ROWS];
    logic [1:0]               row_res   [NUM_ROWS];
    logic                     row_mid   [NUM_ROWS];
    logic [`SAR_CAL_BITS-1:0] row_cal   [NUM_ROWS];
    logic                     row_en    [NUM_ROWS];
    logic [`SAR_MAX_BITS-1:0] row_level [NUM_ROWS];
    logic [`SAR_MAX_BITS-1:0] row_high  [NUM_ROWS];
    logic [`SAR_MAX_BITS-1:0] row_low   [NUM_ROWS];
    logic [`SAR_MAX_BITS-1:0] row_sw_mid[NUM_ROWS];
    int                       n_rows = 0;

    // Row indices accepted but not yet delivered, oldest first
    int                       exp_q[$];
    logic [31:0]              lcg_state = 32'h4864;

    sar_dac_top DUT (
        .clk_i        (clk_i),
        .reset_n_i    (reset_n_i),
        .req_valid_i  (req_valid_i),
        .req_ready_o  (req_ready_o),
        .req_code_i   (req_code_i),
        .req_res_i    (req_res_i),
        .req_mid_i    (req_mid_i),
        .cal_valid_i  (cal_valid_i),
        .cal_code_i   (cal_code_i),
        .cal_enable_i (cal_enable_i),
        .out_valid_o  (out_valid_o),
        .out_ready_i  (out_ready_i),
        .out_level_o  (out_level_o),
        .sw_high_o    (sw_high_o),
        .sw_low_o     (sw_low_o),
        .sw_mid_o     (sw_mid_o),
        .busy_o       (busy_o)
    );

    initial begin
        clk_i = 1'b0;
        forever #2 clk_i = ~clk_i;
    end

    //==================================================================
    // Helpers
    //==================================================================

    function automatic logic [31:0] lcg_next(input logic [31:0] s);
        return s * 32'd1664525 + 32'd1013904223;
    endfunction

    task automatic fail_run(input string msg);
        $display("%s", msg);
        $display("*** FAILED ***");
        $fatal(1);
    endtask

    task automatic check_word(input string name, input logic [`SAR_MAX_BITS-1:0] got,
                              input logic [`SAR_MAX_BITS-1:0] exp);
        assert (got === exp)
        else fail_run($sformatf("CHECK FAILED %s got 0x%04h expected 0x%04h", name, got, exp));
    endtask

    task automatic check_bit(input string name, input logic got, input logic exp);
        assert (got === exp)
        else fail_run($sformatf("CHECK FAILED %s got 0x%0h expected 0x%0h", name, got, exp));
    endtask

    task automatic put_row(input logic [15:0] code, input logic [1:0] res, input logic mid,
                           input logic [7:0] cal, input logic en, input logic [15:0] level,
                           input logic [15:0] high, input logic [15:0] low,
                           input logic [15:0] swm);
        row_code[n_rows]   = code;
        row_res[n_rows]    = res;
        row_mid[n_rows]    = mid;
        row_cal[n_rows]    = cal;
        row_en[n_rows]     = en;
        row_level[n_rows]  = level;
        row_high[n_rows]   = high;
        row_low[n_rows]    = low;
        row_sw_mid[n_rows] = swm;
        n_rows++;
    endtask

    // code res mid cal en | level high low mid
    task automatic fill_table();
        // Plain masking at every resolution, trim off
        put_row(16'hABCD, 2'd0, 1'b0, 8'h88, 1'b0, 16'h0BCD, 16'h0BCD, 16'h0432, 16'hF000);
        put_row(16'hABCD, 2'd1, 1'b0, 8'h88, 1'b0, 16'h2BCD, 16'h2BCD, 16'h1432, 16'hC000);
        put_row(16'hABCD, 2'd2, 1'b0, 8'h88, 1'b0, 16'hABCD, 16'hABCD, 16'h5432, 16'h0000);
        put_row(16'h1234, 2'd3, 1'b0, 8'h88, 1'b0, 16'h1234, 16'h1234, 16'hEDCB, 16'h0000);
        // Midscale forces the top used bit and parks every capacitor
        put_row(16'hFFFF, 2'd0, 1'b1, 8'h88, 1'b0, 16'h0800, 16'h0000, 16'h0000, 16'hFFFF);
        put_row(16'h1234, 2'd1, 1'b1, 8'h88, 1'b0, 16'h2000, 16'h0000, 16'h0000, 16'hFFFF);
        put_row(16'h0000, 2'd2, 1'b1, 8'h88, 1'b0, 16'h8000, 16'h0000, 16'h0000, 16'hFFFF);
        put_row(16'h0000, 2'd0, 1'b0, 8'h88, 1'b0, 16'h0000, 16'h0000, 16'h0FFF, 16'hF000);
        put_row(16'hFFFF, 2'd2, 1'b0, 8'h88, 1'b0, 16'hFFFF, 16'hFFFF, 16'h0000, 16'h0000);
        // Offset +2, clamps at 12-bit full scale
        put_row(16'h0100, 2'd0, 1'b0, 8'h8A, 1'b1, 16'h0102, 16'h0100, 16'h0EFF, 16'hF000);
        put_row(16'h0FFF, 2'd0, 1'b0, 8'h8A, 1'b1, 16'h0FFF, 16'h0FFF, 16'h0000, 16'hF000);
        // Offset -8 pulls below zero
        put_row(16'h0005, 2'd2, 1'b0, 8'h80, 1'b1, 16'h0000, 16'h0005, 16'hFFFA, 16'h0000);
        // Gain +4 steps
        put_row(16'h1000, 2'd1, 1'b0, 8'hC8, 1'b1, 16'h1010, 16'h1000, 16'h2FFF, 16'hC000);
        // Gain -4 steps, shift floors toward minus infinity
        put_row(16'h8000, 2'd2, 1'b0, 8'h48, 1'b1, 16'h7F80, 16'h8000, 16'h7FFF, 16'h0000);
        put_row(16'h0001, 2'd2, 1'b0, 8'h48, 1'b1, 16'h0000, 16'h0001, 16'hFFFE, 16'h0000);
        // Gain +7 and offset +1
        put_row(16'hFFFF, 2'd2, 1'b0, 8'hF9, 1'b1, 16'hFFFF, 16'hFFFF, 16'h0000, 16'h0000);
        put_row(16'hF000, 2'd2, 1'b0, 8'hF9, 1'b1, 16'hF1A5, 16'hF000, 16'h0FFF, 16'h0000);
        put_row(16'h3FFF, 2'd1, 1'b0, 8'hF9, 1'b1, 16'h3FFF, 16'h3FFF, 16'h0000, 16'hC000);
        put_row(16'h0000, 2'd0, 1'b1, 8'hF9, 1'b1, 16'h080F, 16'h0000, 16'h0000, 16'hFFFF);
        // Same word loaded but bypassed
        put_row(16'hF000, 2'd2, 1'b0, 8'hF9, 1'b0, 16'hF000, 16'hF000, 16'h0FFF, 16'h0000);
        put_row(16'h0005, 2'd2, 1'b0, 8'hF9, 1'b0, 16'h0005, 16'h0005, 16'hFFFA, 16'h0000);
    endtask

    // Called on a falling edge, returns on the falling edge after the transfer
    task automatic send_row(input int idx);
        req_valid_i = 1'b1;
        req_code_i  = row_code[idx];
        req_res_i   = row_res[idx];
        req_mid_i   = row_mid[idx];
        exp_q.push_back(idx);
        #1;
        while (!req_ready_o) begin
            @(negedge clk_i);
            #1;
        end
        @(negedge clk_i);
    endtask

    // Every accepted request delivered, settle stage empty
    task automatic drain_pipeline();
        while (exp_q.size() != 0)
            @(negedge clk_i);
    endtask

    task automatic apply_calibration(input logic [`SAR_CAL_BITS-1:0] word, input logic en);
        cal_code_i   = word;
        cal_enable_i = en;
        cal_valid_i  = 1'b1;
        @(negedge clk_i);
        cal_valid_i  = 1'b0;
    endtask

    //==================================================================
    // Main sequence
    //==================================================================

    initial begin : main_sequence
        int i;
        reset_n_i    = 1'b0;
        req_valid_i  = 1'b0;
        req_code_i   = '0;
        req_res_i    = 2'd0;
        req_mid_i    = 1'b0;
        cal_valid_i  = 1'b0;
        cal_code_i   = '0;
        cal_enable_i = 1'b0;
        fill_table();
        assert (n_rows == NUM_ROWS)
        else fail_run("stimulus table size does not match its declared row count");
        repeat (RESET_CYCLES) @(negedge clk_i);
        reset_n_i = 1'b1;
        #1;
        // Idle state right after reset
        check_bit("out_valid_o", out_valid_o, 1'b0);
        check_bit("busy_o", busy_o, 1'b0);
        check_bit("req_ready_o", req_ready_o, 1'b1);
        check_word("sw_mid_o", sw_mid_o, 16'hFFFF);
        check_word("sw_high_o", sw_high_o, 16'h0000);
        check_word("sw_low_o", sw_low_o, 16'h0000);
        @(negedge clk_i);
        for (i = 0; i < NUM_ROWS; i++) begin
            // New calibration only goes in with nothing in flight
            if (i == 0 || row_cal[i] != row_cal[i-1] || row_en[i] != row_en[i-1]) begin
                req_valid_i = 1'b0;
                drain_pipeline();
                apply_calibration(row_cal[i], row_en[i]);
            end
            send_row(i);
        end
        req_valid_i = 1'b0;
        drain_pipeline();
        if (exp_q.size() == 0 && !out_valid_o) begin
            $display("*** PASSED ***");
            $finish;
        end else begin
            fail_run("pipeline still held a result after all requests were delivered");
        end
    end

    //==================================================================
    // Output side: random stalls and result checks
    //==================================================================

    initial begin : output_monitor
        int idx;
        out_ready_i = 1'b0;
        @(posedge reset_n_i);
        forever begin
            @(negedge clk_i);
            lcg_state = lcg_next(lcg_state);
            // Consumer stalls about one cycle in four
            out_ready_i = (lcg_state[31:30] != 2'b00);
            #1;
            assert (!out_valid_o || busy_o)
            else fail_run("busy_o was low while out_valid_o was high");
            if (out_valid_o && out_ready_i) begin
                assert (exp_q.size() != 0)
                else fail_run("result delivered with no request outstanding");
                idx = exp_q.pop_front();
                check_word("out_level_o", out_level_o, row_level[idx]);
                check_word("sw_high_o", sw_high_o, row_high[idx]);
                check_word("sw_low_o", sw_low_o, row_low[idx]);
                check_word("sw_mid_o", sw_mid_o, row_sw_mid[idx]);
            end
        end
    end

    initial begin : watchdog
        repeat (WATCHDOG_CYCLES) @(posedge clk_i);
        fail_run("Timeout: the requests did not all complete in the allowed number of cycles");
    end

endmodule
